// ==== vgaCtrl_settings.svh ====
// ====================
// VGA controller timing, screen and frame-memory geometry
// ====================

`ifndef VGA_CTRL_SETTINGS_SVH
`define VGA_CTRL_SETTINGS_SVH

// ====================
// Horizontal timing in pixel clocks
// ====================
`define VGA_H_VISIBLE     640
`define VGA_H_SYNC_START  656
`define VGA_H_SYNC_END    752
`define VGA_H_TOTAL       800

// ====================
// Vertical timing in lines
// ====================
`define VGA_V_VISIBLE     480
`define VGA_V_SYNC_START  490
`define VGA_V_SYNC_END    492
`define VGA_V_TOTAL       525

// ====================
// Frame memory geometry
// ====================
// One word per 8x4 pixel block
`define VGA_WORDS_PER_ROW 80
// 120 word rows of 80 words
`define VGA_MEM_WORDS     9600
`define VGA_MEM_ADDR_W    14

`endif

// ==== vgaPkg.sv ====
// ====================
// VGA controller shared types
// ====================

`default_nettype none

`include "vgaCtrl_settings.svh"

package vgaPkg;

    // Pixel or line counter, wide enough for 800 and 525
    typedef logic [9:0] coordT;

    // Frame-memory word address
    typedef logic [`VGA_MEM_ADDR_W-1:0] memAddrT;

    // Core data word, also one 8x4 pixel block
    typedef logic [31:0] wordT;

    // One enable per byte of a word
    typedef logic [3:0] byteEnT;

    // Single colour channel
    typedef logic [3:0] colourT;

    // Vertical section of the frame
    typedef enum logic [1:0] {
        lineActive,
        lineFront,
        lineSync,
        lineBack
    } lineStateT;

endpackage

`default_nettype wire

// ==== vgaMemIf.sv ====
// ====================
// Core access port of the VGA frame memory
// ====================

`default_nettype none

interface vgaMemIf
    import vgaPkg::*;
();

    // Write data, full word
    wordT   reqData;
    // Byte address from the core
    wordT   reqAddress;
    // Per-byte write enables
    byteEnT byteEn;
    // Single-cycle strobes, no back-pressure
    logic   wrEn;
    logic   rdEn;
    // Read data, one cycle after the request
    wordT   rspData;

    // Core side drives the request
    modport core (
        output reqData,
        output reqAddress,
        output byteEn,
        output wrEn,
        output rdEn,
        input  rspData
    );

    // Memory side returns the word
    modport mem (
        input  reqData,
        input  reqAddress,
        input  byteEn,
        input  wrEn,
        input  rdEn,
        output rspData
    );

endinterface

`default_nettype wire

// ==== vgaSyncGen.sv ====
// ====================
// VGA sync generator with pixel strobe and scan counters
// ====================

`default_nettype none

`include "vgaCtrl_settings.svh"

module vgaSyncGen
    import vgaPkg::*;
(
    input  logic  Clk_50,
    input  logic  reset,
    output logic  pixelEn,
    output coordT counterX,
    output coordT counterY,
    output logic  inDisplayArea,
    output logic  hSyncRaw,
    output logic  vSyncRaw
);

    logic      lineEnd;
    coordT     nextY;
    lineStateT lineState;
    lineStateT nextLineState;

    // ====================
    // Pixel strobe
    // ====================
    // Half rate of Clk_50, low in first cycle after reset
    always_ff @(posedge Clk_50) begin
        if (reset) begin
            pixelEn <= 1'b0;
        end else begin
            pixelEn <= ~pixelEn;
        end
    end

    // ====================
    // Scan counters
    // ====================
    assign lineEnd = (counterX == coordT'(`VGA_H_TOTAL - 1));

    // Line number after the current one, wraps at frame end
    assign nextY = (counterY == coordT'(`VGA_V_TOTAL - 1)) ? '0 : coordT'(counterY + 1'b1);

    always_ff @(posedge Clk_50) begin
        if (reset) begin
            counterX <= '0;
            counterY <= '0;
        end else if (pixelEn) begin
            if (lineEnd) begin
                counterX <= '0;
                counterY <= nextY;
            end else begin
                counterX <= coordT'(counterX + 1'b1);
            end
        end
    end

    // ====================
    // Vertical section FSM
    // ====================
    // Moves together with counterY, so it always matches the current line
    always_comb begin
        nextLineState = lineState;
        case (lineState)
            lineActive: if (nextY == coordT'(`VGA_V_VISIBLE))    nextLineState = lineFront;
            lineFront:  if (nextY == coordT'(`VGA_V_SYNC_START)) nextLineState = lineSync;
            lineSync:   if (nextY == coordT'(`VGA_V_SYNC_END))   nextLineState = lineBack;
            lineBack:   if (nextY == '0)                         nextLineState = lineActive;
            default:    nextLineState = lineActive;
        endcase
    end

    always_ff @(posedge Clk_50) begin
        if (reset) begin
            lineState <= lineActive;
        end else if (pixelEn && lineEnd) begin
            lineState <= nextLineState;
        end
    end

    // ====================
    // Sync and display decode
    // ====================
    // Low-active pulses
    assign hSyncRaw = ~((counterX >= coordT'(`VGA_H_SYNC_START)) &&
                        (counterX <  coordT'(`VGA_H_SYNC_END)));
    assign vSyncRaw = (lineState != lineSync);

    assign inDisplayArea = (counterX < coordT'(`VGA_H_VISIBLE)) &&
                           (counterY < coordT'(`VGA_V_VISIBLE));

endmodule

`default_nettype wire

// ==== vgaFrameMem.sv ====
// ====================
// VGA frame memory, byte-enabled core port and scan read port
// ====================

`default_nettype none

`include "vgaCtrl_settings.svh"

module vgaFrameMem
    import vgaPkg::*;
(
    input  logic    Clk_50,
    vgaMemIf.mem    core,
    input  logic    pixelEn,
    input  memAddrT scanAddr,
    output wordT    scanData
);

    // One word per 8x4 pixel block
    wordT    ram [`VGA_MEM_WORDS];
    memAddrT coreAddr;

    // ====================
    // Core port
    // ====================
    // Byte address to word address
    assign coreAddr = core.reqAddress[`VGA_MEM_ADDR_W+1:2];

    // Only enabled bytes change
    always_ff @(posedge Clk_50) begin
        if (core.wrEn) begin
            for (int b = 0; b < 4; b++) begin
                if (core.byteEn[b]) begin
                    ram[coreAddr][b*8 +: 8] <= core.reqData[b*8 +: 8];
                end
            end
        end
    end

    // Registered read of the addressed word every cycle
    // Same-cycle write to the same word returns old data
    always_ff @(posedge Clk_50) begin
        core.rspData <= ram[coreAddr];
    end

    // ====================
    // Scan port
    // ====================
    // Read-only, advances with the pixel strobe
    always_ff @(posedge Clk_50) begin
        if (pixelEn) begin
            scanData <= ram[scanAddr];
        end
    end

endmodule

`default_nettype wire

// ==== vgaPixelFetch.sv ====
// ====================
// VGA pixel fetch, scan addressing and two-stage output pipeline
// ====================

`default_nettype none

`include "vgaCtrl_settings.svh"

module vgaPixelFetch
    import vgaPkg::*;
(
    input  logic    Clk_50,
    input  logic    reset,
    input  logic    pixelEn,
    input  coordT   counterX,
    input  coordT   counterY,
    input  logic    inDisplayArea,
    input  logic    hSyncRaw,
    input  logic    vSyncRaw,
    output memAddrT scanAddr,
    input  wordT    scanData,
    output colourT  red,
    output colourT  green,
    output colourT  blue,
    output logic    hSync,
    output logic    vSync,
    output logic    displayOn
);

    memAddrT   rowBase;
    logic [4:0] bitSelQ1;
    logic      displayQ1;
    logic      hSyncQ1;
    logic      vSyncQ1;
    logic      pixelBit;
    colourT    nextColour;

    // ====================
    // Stage 0 scan address
    // ====================
    // Word row is y / 4, 80 words per row
    assign rowBase  = memAddrT'(counterY[9:2]) * memAddrT'(`VGA_WORDS_PER_ROW);

    // Word column is x / 8
    assign scanAddr = rowBase + memAddrT'(counterX[9:3]);

    // ====================
    // Stage 1 alignment
    // ====================
    // Bit select held until the memory word returns
    // Byte row from y mod 4, bit from x mod 8
    always_ff @(posedge Clk_50) begin
        if (pixelEn) begin
            bitSelQ1 <= {counterY[1:0], counterX[2:0]};
        end
    end

    // Display flag and syncs follow the same delay
    always_ff @(posedge Clk_50) begin
        if (reset) begin
            displayQ1 <= 1'b0;
            hSyncQ1   <= 1'b1;
            vSyncQ1   <= 1'b1;
        end else if (pixelEn) begin
            displayQ1 <= inDisplayArea;
            hSyncQ1   <= hSyncRaw;
            vSyncQ1   <= vSyncRaw;
        end
    end

    // ====================
    // Stage 2 pixel select
    // ====================
    assign pixelBit = scanData[bitSelQ1];

    // Set bit gives white, anything off-screen is black
    assign nextColour = displayQ1 ? {4{pixelBit}} : '0;

    // Output registers
    always_ff @(posedge Clk_50) begin
        if (reset) begin
            red       <= '0;
            green     <= '0;
            blue      <= '0;
            hSync     <= 1'b1;
            vSync     <= 1'b1;
            displayOn <= 1'b0;
        end else if (pixelEn) begin
            red       <= nextColour;
            green     <= nextColour;
            blue      <= nextColour;
            hSync     <= hSyncQ1;
            vSync     <= vSyncQ1;
            displayOn <= displayQ1;
        end
    end

endmodule

`default_nettype wire

// ==== vgaCtrl.sv ====
// ====================
// VGA controller top, sync generator, pixel fetch and frame memory
// ====================

`default_nettype none

module vgaCtrl
    import vgaPkg::*;
(
    input  logic   Clk_50,
    input  logic   reset,
    // Core access to the frame memory
    input  wordT   reqData,
    input  wordT   reqAddress,
    input  byteEnT byteEn,
    input  logic   wrEn,
    input  logic   rdEn,
    output wordT   rspData,
    // Scan position
    output coordT  counterX,
    output coordT  counterY,
    // VGA output
    output colourT red,
    output colourT green,
    output colourT blue,
    output logic   hSync,
    output logic   vSync,
    output logic   displayOn
);

    logic    pixelEn;
    logic    inDisplayArea;
    logic    hSyncRaw;
    logic    vSyncRaw;
    memAddrT scanAddr;
    wordT    scanData;

    // ====================
    // Core port bundle
    // ====================
    vgaMemIf memIf ();

    assign memIf.reqData    = reqData;
    assign memIf.reqAddress = reqAddress;
    assign memIf.byteEn     = byteEn;
    assign memIf.wrEn       = wrEn;
    assign memIf.rdEn       = rdEn;
    assign rspData          = memIf.rspData;

    // ====================
    // Scan path
    // ====================
    vgaSyncGen u_syncGen (
        .Clk_50        (Clk_50),
        .reset         (reset),
        .pixelEn       (pixelEn),
        .counterX      (counterX),
        .counterY      (counterY),
        .inDisplayArea (inDisplayArea),
        .hSyncRaw      (hSyncRaw),
        .vSyncRaw      (vSyncRaw)
    );

    vgaPixelFetch u_pixelFetch (
        .Clk_50        (Clk_50),
        .reset         (reset),
        .pixelEn       (pixelEn),
        .counterX      (counterX),
        .counterY      (counterY),
        .inDisplayArea (inDisplayArea),
        .hSyncRaw      (hSyncRaw),
        .vSyncRaw      (vSyncRaw),
        .scanAddr      (scanAddr),
        .scanData      (scanData),
        .red           (red),
        .green         (green),
        .blue          (blue),
        .hSync         (hSync),
        .vSync         (vSync),
        .displayOn     (displayOn)
    );

    // Core port and scan port share one RAM
    vgaFrameMem u_frameMem (
        .Clk_50   (Clk_50),
        .core     (memIf.mem),
        .pixelEn  (pixelEn),
        .scanAddr (scanAddr),
        .scanData (scanData)
    );

endmodule

`default_nettype wire

// ==== vgaCtrlTb.sv ====
// ====================
// VGA controller testbench, model frame with scan and core port checks
// ====================

`default_nettype none

`include "vgaCtrl_settings.svh"

module vgaCtrlTb
    import vgaPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // ====================
    // Test lengths
    // ====================
    localparam int rwOps          = 64;
    localparam int checkedFrames  = 3;
    localparam int frameCycles    = 2 * `VGA_H_TOTAL * `VGA_V_TOTAL;
    localparam int setupCycles    = 2 * `VGA_MEM_WORDS + 4 * rwOps;
    // Unchecked first frame plus checked frames, setup and one refill
    localparam int watchdogCycles = (checkedFrames + 1) * frameCycles + 2 * setupCycles;
    localparam int pixelsPerFrame = `VGA_H_VISIBLE * `VGA_V_VISIBLE;

    logic   Clk_50 = 1'b0;
    logic   reset;
    wordT   reqData;
    wordT   reqAddress;
    byteEnT byteEn;
    logic   wrEn;
    logic   rdEn;
    wordT   rspData;
    coordT  counterX;
    coordT  counterY;
    colourT red;
    colourT green;
    colourT blue;
    logic   hSync;
    logic   vSync;
    logic   displayOn;

    // Reference copy of the frame memory
    wordT modelFrame [`VGA_MEM_WORDS];
    int   seed = 24634;
    bit   scanRunning = 1'b0;
    bit   colourCheckArmed = 1'b0;
    int   colourChecks = 0;
    // Cycles since reset release
    int   scanCycle = 0;
    // Scan positions waiting for their pixel
    int   sampleX [$];
    int   sampleY [$];
    bit   sampleArmed [$];

    vgaCtrl u_vgaCtrl (
        .Clk_50     (Clk_50),
        .reset      (reset),
        .reqData    (reqData),
        .reqAddress (reqAddress),
        .byteEn     (byteEn),
        .wrEn       (wrEn),
        .rdEn       (rdEn),
        .rspData    (rspData),
        .counterX   (counterX),
        .counterY   (counterY),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .hSync      (hSync),
        .vSync      (vSync),
        .displayOn  (displayOn)
    );

    always #5 Clk_50 = ~Clk_50;

    // ====================
    // Reference model
    // ====================
    // 8x4 block per word, byte is block row, bit is block column
    function automatic bit refPixel(input int x, input int y);
        memAddrT    wordIdx;
        logic [4:0] bitIdx;
        wordIdx = memAddrT'((y / 4) * `VGA_WORDS_PER_ROW + x / 8);
        bitIdx  = 5'((y % 4) * 8 + x % 8);
        return modelFrame[wordIdx][bitIdx];
    endfunction

    task automatic checkValue(input string name, input wordT actual, input wordT expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Outputs for one scan position, two strobes after it was shown
    task automatic compareOutputs(input int x, input int y, input bit armed);
        logic   expHs;
        logic   expVs;
        logic   expDisp;
        colourT expColour;
        expHs   = !((x >= `VGA_H_SYNC_START) && (x < `VGA_H_SYNC_END));
        expVs   = !((y >= `VGA_V_SYNC_START) && (y < `VGA_V_SYNC_END));
        expDisp = (x < `VGA_H_VISIBLE) && (y < `VGA_V_VISIBLE);
        checkValue("hSync", 32'(hSync), 32'(expHs));
        checkValue("vSync", 32'(vSync), 32'(expVs));
        checkValue("displayOn", 32'(displayOn), 32'(expDisp));
        // Off-screen is always black, visible only once memory is known
        if (!expDisp || armed) begin
            expColour = (expDisp && refPixel(x, y)) ? 4'hF : 4'h0;
            checkValue("red", 32'(red), 32'(expColour));
            checkValue("green", 32'(green), 32'(expColour));
            checkValue("blue", 32'(blue), 32'(expColour));
            if (expDisp) begin
                colourChecks++;
            end
        end
    endtask

    // Four-cycle delay line from counters to outputs
    // Scan position steps once every two cycles from reset
    always @(negedge Clk_50) begin
        if (scanRunning) begin
            checkValue("counterX", 32'(counterX), 32'((scanCycle / 2) % `VGA_H_TOTAL));
            checkValue("counterY", 32'(counterY),
                       32'((scanCycle / 2 / `VGA_H_TOTAL) % `VGA_V_TOTAL));
            scanCycle++;
            sampleX.push_back(int'(counterX));
            sampleY.push_back(int'(counterY));
            sampleArmed.push_back(colourCheckArmed);
            if (sampleX.size() > 4) begin
                compareOutputs(sampleX.pop_front(), sampleY.pop_front(), sampleArmed.pop_front());
            end
        end
    end

    // ====================
    // Core port stimulus
    // ====================
    task automatic writeWord(input memAddrT addr, input wordT data, input byteEnT be);
        @(posedge Clk_50);
        reqAddress <= wordT'({addr, 2'b00});
        reqData    <= data;
        byteEn     <= be;
        wrEn       <= 1'b1;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                modelFrame[addr][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        @(posedge Clk_50);
        wrEn <= 1'b0;
    endtask

    // Word comes back one cycle after the strobe
    task automatic readCheck(input memAddrT addr);
        @(posedge Clk_50);
        reqAddress <= wordT'({addr, 2'b00});
        rdEn       <= 1'b1;
        @(posedge Clk_50);
        rdEn <= 1'b0;
        @(negedge Clk_50);
        checkValue("rspData", rspData, modelFrame[addr]);
    endtask

    function automatic memAddrT randomAddr();
        int r;
        r = $random(seed);
        return memAddrT'((r & 32'h7fff_ffff) % `VGA_MEM_WORDS);
    endfunction

    task automatic byteEnableTest();
        memAddrT addr;
        wordT    data;
        byteEnT  be;
        for (int i = 0; i < rwOps; i++) begin
            addr = randomAddr();
            data = $random(seed);
            be   = byteEnT'($random(seed));
            writeWord(addr, data, be);
            readCheck(addr);
        end
    endtask

    task automatic fillFrame(input bit allOnes);
        for (int a = 0; a < `VGA_MEM_WORDS; a++) begin
            writeWord(memAddrT'(a), allOnes ? 32'hFFFF_FFFF : wordT'($random(seed)), 4'hF);
        end
    endtask

    // Inverts an 8x4 word block, so every pixel in it changes
    task automatic rewriteBlock();
        memAddrT addr;
        for (int r = 30; r < 34; r++) begin
            for (int c = 10; c < 18; c++) begin
                addr = memAddrT'(r * `VGA_WORDS_PER_ROW + c);
                writeWord(addr, ~modelFrame[addr], 4'hF);
            end
        end
    endtask

    task automatic waitLine(input int line);
        @(negedge Clk_50);
        while (int'(counterY) != line) begin
            @(negedge Clk_50);
        end
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        reset      = 1'b1;
        reqData    = '0;
        reqAddress = '0;
        byteEn     = '0;
        wrEn       = 1'b0;
        rdEn       = 1'b0;
        repeat (3) @(posedge Clk_50);
        reset <= 1'b0;
        scanRunning = 1'b1;
        @(negedge Clk_50);
        checkValue("red", 32'(red), 32'h0);
        checkValue("green", 32'(green), 32'h0);
        checkValue("blue", 32'(blue), 32'h0);
        checkValue("hSync", 32'(hSync), 32'h1);
        checkValue("vSync", 32'(vSync), 32'h1);
        checkValue("displayOn", 32'(displayOn), 32'h0);
        // Frame 0 loads random data and runs the core port
        fillFrame(1'b0);
        byteEnableTest();
        waitLine(`VGA_V_VISIBLE);
        @(posedge Clk_50);
        colourCheckArmed = 1'b1;
        // Frame 1 against the random frame
        waitLine(0);
        waitLine(`VGA_V_VISIBLE);
        // Frame 2 shows the inverted block
        rewriteBlock();
        waitLine(0);
        waitLine(`VGA_V_VISIBLE);
        // Frame 3 with all ones, blanking stays black
        fillFrame(1'b1);
        waitLine(0);
        waitLine(`VGA_V_VISIBLE);
        if (colourChecks != checkedFrames * 2 * pixelsPerFrame) begin
            $display("Only %0d visible pixel checks ran", colourChecks);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Visible pixel check count is wrong");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    // Watchdog
    initial begin
        #(watchdogCycles * 10);
        $display("Watchdog expired before the last frame was scanned");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
vgaPkg.sv
vgaMemIf.sv
vgaSyncGen.sv
vgaFrameMem.sv
vgaPixelFetch.sv
vgaCtrl.sv
vgaCtrlTb.sv

// ==== Makefile ====
# Verilator build and run of the VGA controller testbench

VERILATOR ?= verilator
TOP       ?= vgaCtrlTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
